//--- logic/tim_geom_pkg.sv
package tim_geom_pkg;

  // number of interleaved banks, kept a power of two.
  localparam int default_bank_count = 4;

  // 64-bit words held by each bank.
  localparam int default_bank_depth = 256;

  // low address bits that select a byte inside one word.
  localparam int word_offset_bits = 3;

  localparam int byte_bits = 8;
  localparam int bytes_per_word = 1 << word_offset_bits; // byte lanes per word.

  // ram_block gates reads and writes with the bank enable.
  // ram_lut writes on the strobes alone and reads every cycle.
  typedef enum logic {
    ram_block,
    ram_lut
  } ram_style_e;

endpackage

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int strb_width = data_width / 8; // one strobe per byte.

  typedef logic [addr_width-1:0] mem_addr_t;
  typedef logic [data_width-1:0] mem_data_t;
  typedef logic [strb_width-1:0] mem_strb_t;

endpackage

//--- logic/tim_bank.sv
`timescale 1ns/1ps

module tim_bank #(
  parameter int depth = 256,
  parameter tim_geom_pkg::ram_style_e ram_style = tim_geom_pkg::ram_block
) (
  input  logic                         clock,
  input  logic                         a_en,
  input  logic                         b_en,
  input  logic [$clog2(depth)-1:0]     a_index,
  input  logic [$clog2(depth)-1:0]     b_index,
  input  mem_bus_pkg::mem_strb_t       a_wstrb,
  input  mem_bus_pkg::mem_strb_t       b_wstrb,
  input  mem_bus_pkg::mem_data_t       a_wdata,
  input  mem_bus_pkg::mem_data_t       b_wdata,
  output mem_bus_pkg::mem_data_t       a_rdata,
  output mem_bus_pkg::mem_data_t       b_rdata
);

  localparam int byte_bits = tim_geom_pkg::byte_bits;
  localparam int lanes = tim_geom_pkg::bytes_per_word;
  localparam logic lut_style = (ram_style == tim_geom_pkg::ram_lut);

  mem_bus_pkg::mem_data_t ram [depth] = '{default: '0};

  logic a_active;
  logic b_active;

  // a lut style bank ignores the enable, the strobes alone decide a write.
  assign a_active = lut_style || a_en;
  assign b_active = lut_style || b_en;

  always_ff @(posedge clock) begin
    if (a_active) begin
      for (int i = 0; i < lanes; i++) begin
        if (a_wstrb[i]) begin
          ram[a_index][i*byte_bits +: byte_bits] <= a_wdata[i*byte_bits +: byte_bits];
        end
      end
      a_rdata <= ram[a_index]; // old word, the write lands after this edge.
    end
    if (b_active) begin
      for (int i = 0; i < lanes; i++) begin
        if (b_wstrb[i]) begin
          ram[b_index][i*byte_bits +: byte_bits] <= b_wdata[i*byte_bits +: byte_bits];
        end
      end
      b_rdata <= ram[b_index];
    end
  end

  // The two fronts share this bank, so a byte written by both in one cycle
  // would have no defined winner.
  assert property (@(posedge clock)
    !(a_active && b_active && (a_index == b_index) && |(a_wstrb & b_wstrb)))
    else $error("tim_bank: both ports write the same bytes of index %0d", a_index);

endmodule

//--- logic/tim_port_front.sv
`timescale 1ns/1ps

module tim_port_front #(
  parameter int bank_count = 4,
  parameter int bank_depth = 256
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            valid,
  input  mem_bus_pkg::mem_addr_t          addr,
  input  mem_bus_pkg::mem_strb_t          wstrb,
  input  mem_bus_pkg::mem_data_t          wdata,
  output logic [bank_count-1:0]           bank_en,
  output logic [$clog2(bank_depth)-1:0]   index,
  output mem_bus_pkg::mem_strb_t          bank_wstrb,
  output mem_bus_pkg::mem_data_t          bank_wdata,
  output logic                            r_valid,
  output logic [$clog2(bank_count)-1:0]   r_bank,
  output logic [$clog2(bank_depth)-1:0]   r_index,
  output mem_bus_pkg::mem_strb_t          r_wstrb,
  output mem_bus_pkg::mem_data_t          r_wdata
);

  localparam int bank_bits = $clog2(bank_count);
  localparam int index_bits = $clog2(bank_depth);
  localparam int bank_lsb = tim_geom_pkg::word_offset_bits;
  localparam int index_lsb = bank_lsb + bank_bits;

  logic [bank_bits-1:0] bank;

  assign bank = addr[bank_lsb +: bank_bits]; // consecutive words go to consecutive banks.
  assign index = addr[index_lsb +: index_bits];
  assign bank_wstrb = valid ? wstrb : '0;
  assign bank_wdata = wdata;

  always_comb begin
    bank_en = '0;
    if (valid) begin
      bank_en[bank] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= valid;
    end
  end

  // held for the back stage while the banks read.
  always_ff @(posedge clock) begin
    r_bank <= bank;
    r_index <= index;
    r_wstrb <= bank_wstrb;
    r_wdata <= wdata;
  end

  assert property (@(posedge clock) disable iff (!reset)
    valid |-> ((addr >> bank_lsb) < bank_count * bank_depth))
    else $error("tim_port_front: address %h is outside the memory", addr);

endmodule

//--- logic/tim_resp_merge.sv
`timescale 1ns/1ps

module tim_resp_merge #(
  parameter int bank_count = 4,
  parameter int bank_depth = 256
) (
  input  logic                            p0_valid,
  input  logic                            p1_valid,
  input  logic [$clog2(bank_count)-1:0]   p0_bank,
  input  logic [$clog2(bank_count)-1:0]   p1_bank,
  input  logic [$clog2(bank_depth)-1:0]   p0_index,
  input  logic [$clog2(bank_depth)-1:0]   p1_index,
  input  mem_bus_pkg::mem_strb_t          p0_wstrb,
  input  mem_bus_pkg::mem_strb_t          p1_wstrb,
  input  mem_bus_pkg::mem_data_t          p0_wdata,
  input  mem_bus_pkg::mem_data_t          bank0_rdata [bank_count],
  input  mem_bus_pkg::mem_data_t          bank1_rdata [bank_count],
  output logic                            mem0_ready,
  output logic                            mem1_ready,
  output mem_bus_pkg::mem_data_t          mem0_rdata,
  output mem_bus_pkg::mem_data_t          mem1_rdata
);

  localparam int byte_bits = tim_geom_pkg::byte_bits;
  localparam int lanes = tim_geom_pkg::bytes_per_word;

  logic p0_write;
  logic p1_write;
  logic same_word;
  logic forward;

  assign p0_write = p0_valid && |p0_wstrb;
  assign p1_write = p1_valid && |p1_wstrb;
  assign same_word = (p0_bank == p1_bank) && (p0_index == p1_index);

  // port 1 read the old word at the same edge that port 0 wrote it.
  assign forward = p0_write && p1_valid && !p1_write && same_word;

  assign mem0_ready = p0_valid;
  assign mem1_ready = p1_valid;
  assign mem0_rdata = bank0_rdata[p0_bank];

  always_comb begin
    mem1_rdata = bank1_rdata[p1_bank];
    if (forward) begin
      for (int i = 0; i < lanes; i++) begin
        if (p0_wstrb[i]) begin
          mem1_rdata[i*byte_bits +: byte_bits] = p0_wdata[i*byte_bits +: byte_bits];
        end
      end
    end
  end

endmodule

//--- logic/tim_top.sv
`timescale 1ns/1ps

module tim_top #(
  parameter int bank_count = tim_geom_pkg::default_bank_count,
  parameter int bank_depth = tim_geom_pkg::default_bank_depth,
  parameter tim_geom_pkg::ram_style_e ram_style = tim_geom_pkg::ram_block
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     mem0_valid,
  input  mem_bus_pkg::mem_addr_t   mem0_addr,
  input  mem_bus_pkg::mem_strb_t   mem0_wstrb,
  input  mem_bus_pkg::mem_data_t   mem0_wdata,
  output logic                     mem0_ready,
  output mem_bus_pkg::mem_data_t   mem0_rdata,
  input  logic                     mem1_valid,
  input  mem_bus_pkg::mem_addr_t   mem1_addr,
  input  mem_bus_pkg::mem_strb_t   mem1_wstrb,
  input  mem_bus_pkg::mem_data_t   mem1_wdata,
  output logic                     mem1_ready,
  output mem_bus_pkg::mem_data_t   mem1_rdata
);

  localparam int bank_bits = $clog2(bank_count);
  localparam int index_bits = $clog2(bank_depth);
  localparam int strb_width = mem_bus_pkg::strb_width;

  logic [bank_count-1:0]   f0_bank_en;
  logic [bank_count-1:0]   f1_bank_en;
  logic [index_bits-1:0]   f0_index;
  logic [index_bits-1:0]   f1_index;
  mem_bus_pkg::mem_strb_t  f0_wstrb;
  mem_bus_pkg::mem_strb_t  f1_wstrb;
  mem_bus_pkg::mem_data_t  f0_wdata;
  mem_bus_pkg::mem_data_t  f1_wdata;
  logic                    r0_valid;
  logic                    r1_valid;
  logic [bank_bits-1:0]    r0_bank;
  logic [bank_bits-1:0]    r1_bank;
  logic [index_bits-1:0]   r0_index;
  logic [index_bits-1:0]   r1_index;
  mem_bus_pkg::mem_strb_t  r0_wstrb;
  mem_bus_pkg::mem_strb_t  r1_wstrb;
  mem_bus_pkg::mem_data_t  r0_wdata;
  mem_bus_pkg::mem_data_t  bank0_rdata [bank_count];
  mem_bus_pkg::mem_data_t  bank1_rdata [bank_count];

  tim_port_front #(.bank_count(bank_count), .bank_depth(bank_depth)) u_front0 (
    .clock(clock), .reset(reset), .valid(mem0_valid), .addr(mem0_addr),
    .wstrb(mem0_wstrb), .wdata(mem0_wdata), .bank_en(f0_bank_en), .index(f0_index),
    .bank_wstrb(f0_wstrb), .bank_wdata(f0_wdata), .r_valid(r0_valid), .r_bank(r0_bank),
    .r_index(r0_index), .r_wstrb(r0_wstrb), .r_wdata(r0_wdata)
  );

  // port 1 write data is never forwarded, so its registered copy stays open.
  tim_port_front #(.bank_count(bank_count), .bank_depth(bank_depth)) u_front1 (
    .clock(clock), .reset(reset), .valid(mem1_valid), .addr(mem1_addr),
    .wstrb(mem1_wstrb), .wdata(mem1_wdata), .bank_en(f1_bank_en), .index(f1_index),
    .bank_wstrb(f1_wstrb), .bank_wdata(f1_wdata), .r_valid(r1_valid), .r_bank(r1_bank),
    .r_index(r1_index), .r_wstrb(r1_wstrb), .r_wdata()
  );

  for (genvar i = 0; i < bank_count; i++) begin : g_bank
    mem_bus_pkg::mem_strb_t a_wstrb;
    mem_bus_pkg::mem_strb_t b_wstrb;

    // strobes reach only the selected bank, a lut bank has no enable to stop them.
    assign a_wstrb = f0_wstrb & {strb_width{f0_bank_en[i]}};
    assign b_wstrb = f1_wstrb & {strb_width{f1_bank_en[i]}};

    tim_bank #(.depth(bank_depth), .ram_style(ram_style)) u_bank (
      .clock(clock), .a_en(f0_bank_en[i]), .b_en(f1_bank_en[i]),
      .a_index(f0_index), .b_index(f1_index), .a_wstrb(a_wstrb), .b_wstrb(b_wstrb),
      .a_wdata(f0_wdata), .b_wdata(f1_wdata),
      .a_rdata(bank0_rdata[i]), .b_rdata(bank1_rdata[i])
    );
  end

  tim_resp_merge #(.bank_count(bank_count), .bank_depth(bank_depth)) u_merge (
    .p0_valid(r0_valid), .p1_valid(r1_valid), .p0_bank(r0_bank), .p1_bank(r1_bank),
    .p0_index(r0_index), .p1_index(r1_index), .p0_wstrb(r0_wstrb), .p1_wstrb(r1_wstrb),
    .p0_wdata(r0_wdata), .bank0_rdata(bank0_rdata), .bank1_rdata(bank1_rdata),
    .mem0_ready(mem0_ready), .mem1_ready(mem1_ready),
    .mem0_rdata(mem0_rdata), .mem1_rdata(mem1_rdata)
  );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period = 20,
  parameter int reset_cycles = 3
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0; // active low, held over the first rising edges.
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

//--- verif/tim_tb.sv
`timescale 1ns/1ps

module tim_tb;

  localparam int bank_count = tim_geom_pkg::default_bank_count;
  localparam int bank_depth = tim_geom_pkg::default_bank_depth;
  localparam int offset_bits = tim_geom_pkg::word_offset_bits;
  localparam int word_count = bank_count * bank_depth;
  localparam int table_len = 13;
  localparam int random_count = 200;
  localparam int cycle_limit = 2 * table_len + random_count + 20;

  // one port's request together with its expected response in the next cycle.
  typedef struct packed {
    logic                   valid;
    mem_bus_pkg::mem_addr_t addr;
    mem_bus_pkg::mem_strb_t wstrb;
    mem_bus_pkg::mem_data_t wdata;
    logic                   exp_ready;
    mem_bus_pkg::mem_data_t exp_rdata;
  } step_t;

  // words 0, 1, 3 and 6 sit in banks 0, 1, 3 and 2.
  step_t steps0 [table_len] = '{
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0},
    '{1'b1, 32'h000, 8'hff, 64'h0123_4567_89ab_cdef, 1'b1, 64'h0},
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0},
    '{1'b1, 32'h000, 8'h0f, 64'h5555_6666_7777_8888, 1'b1, 64'h0123_4567_89ab_cdef},
    '{1'b1, 32'h000, 8'h00, 64'h0, 1'b1, 64'h0123_4567_7777_8888},
    '{1'b1, 32'h008, 8'hff, 64'hb0b0_b1b1_b2b2_b3b3, 1'b1, 64'h0},
    '{1'b1, 32'h018, 8'hff, 64'hd0d0_d1d1_d2d2_d3d3, 1'b1, 64'h0},
    '{1'b1, 32'h030, 8'h00, 64'h0, 1'b1, 64'hc0c0_c1c1_c2c2_c3c3},
    '{1'b1, 32'h008, 8'h00, 64'h0, 1'b1, 64'hb0b0_b1b1_b2b2_b3b3},
    '{1'b1, 32'h030, 8'hf0, 64'h1122_3344_5566_7788, 1'b1, 64'hc0c0_c1c1_c2c2_c3c3},
    '{1'b1, 32'h018, 8'h00, 64'h0, 1'b1, 64'hd0d0_d1d1_d2d2_d3d3},
    '{1'b1, 32'h018, 8'h00, 64'h0, 1'b1, 64'hf0f0_f1f1_f2f2_f3f3},
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0}
  };

  step_t steps1 [table_len] = '{
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0},
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0},
    '{1'b1, 32'h000, 8'h00, 64'h0, 1'b1, 64'h0123_4567_89ab_cdef},
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0},
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0},
    '{1'b1, 32'h030, 8'hff, 64'hc0c0_c1c1_c2c2_c3c3, 1'b1, 64'h0},
    '{1'b1, 32'h000, 8'h00, 64'h0, 1'b1, 64'h0123_4567_7777_8888},
    '{1'b1, 32'h008, 8'h00, 64'h0, 1'b1, 64'hb0b0_b1b1_b2b2_b3b3},
    '{1'b1, 32'h018, 8'h00, 64'h0, 1'b1, 64'hd0d0_d1d1_d2d2_d3d3},
    '{1'b1, 32'h030, 8'h00, 64'h0, 1'b1, 64'h1122_3344_c2c2_c3c3}, // sees port 0's new bytes.
    '{1'b1, 32'h018, 8'hff, 64'hf0f0_f1f1_f2f2_f3f3, 1'b1, 64'hd0d0_d1d1_d2d2_d3d3},
    '{1'b1, 32'h030, 8'h00, 64'h0, 1'b1, 64'h1122_3344_c2c2_c3c3},
    '{1'b0, 32'h000, 8'h00, 64'h0, 1'b0, 64'h0}
  };

  logic                   clock;
  logic                   reset;
  logic                   mem0_valid;
  mem_bus_pkg::mem_addr_t mem0_addr;
  mem_bus_pkg::mem_strb_t mem0_wstrb;
  mem_bus_pkg::mem_data_t mem0_wdata;
  logic                   mem0_ready;
  mem_bus_pkg::mem_data_t mem0_rdata;
  logic                   mem1_valid;
  mem_bus_pkg::mem_addr_t mem1_addr;
  mem_bus_pkg::mem_strb_t mem1_wstrb;
  mem_bus_pkg::mem_data_t mem1_wdata;
  logic                   mem1_ready;
  mem_bus_pkg::mem_data_t mem1_rdata;

  step_t                  pending0;
  step_t                  pending1;
  logic                   have_pending;
  mem_bus_pkg::mem_data_t shadow [word_count] = '{default: '0}; // banks start cleared.
  int                     cycles;

  tb_clock_gen #(.period(20), .reset_cycles(3)) u_clock_gen (.clock(clock), .reset(reset));

  tim_top #(
    .bank_count(bank_count),
    .bank_depth(bank_depth),
    .ram_style(tim_geom_pkg::ram_block)
  ) u_dut (
    .clock(clock), .reset(reset),
    .mem0_valid(mem0_valid), .mem0_addr(mem0_addr), .mem0_wstrb(mem0_wstrb),
    .mem0_wdata(mem0_wdata), .mem0_ready(mem0_ready), .mem0_rdata(mem0_rdata),
    .mem1_valid(mem1_valid), .mem1_addr(mem1_addr), .mem1_wstrb(mem1_wstrb),
    .mem1_wdata(mem1_wdata), .mem1_ready(mem1_ready), .mem1_rdata(mem1_rdata)
  );

  function automatic mem_bus_pkg::mem_data_t merge_bytes(input mem_bus_pkg::mem_data_t old_word,
      input mem_bus_pkg::mem_data_t new_word, input mem_bus_pkg::mem_strb_t strb);
    mem_bus_pkg::mem_data_t result;
    result = old_word;
    for (int i = 0; i < mem_bus_pkg::strb_width; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
      input logic [63:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is %h, expected %h", name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "%s does not match", name);
    end
  endtask

  task automatic check_pending();
    check_value("mem0_ready", mem0_ready, pending0.exp_ready);
    check_value("mem1_ready", mem1_ready, pending1.exp_ready);
    if (pending0.exp_ready) begin
      check_value("mem0_rdata", mem0_rdata, pending0.exp_rdata);
    end
    if (pending1.exp_ready) begin
      check_value("mem1_rdata", mem1_rdata, pending1.exp_rdata);
    end
  endtask

  task automatic record_write(input step_t p);
    int w;
    w = p.addr >> offset_bits;
    if (p.valid && |p.wstrb) begin
      shadow[w] = merge_bytes(shadow[w], p.wdata, p.wstrb);
    end
  endtask

  // checks the previous cycle's responses, then drives the new requests.
  task automatic apply_step(input step_t p0, input step_t p1);
    @(negedge clock);
    if (have_pending) begin
      check_pending();
    end
    mem0_valid = p0.valid;
    mem0_addr = p0.addr;
    mem0_wstrb = p0.wstrb;
    mem0_wdata = p0.wdata;
    mem1_valid = p1.valid;
    mem1_addr = p1.addr;
    mem1_wstrb = p1.wstrb;
    mem1_wdata = p1.wdata;
    pending0 = p0;
    pending1 = p1;
    have_pending = 1'b1;
    record_write(p0);
    record_write(p1);
  endtask

  task automatic random_request(output step_t p);
    p.valid = ($urandom % 4) != 0;
    p.addr = ($urandom % 16) << offset_bits; // a few words, so ports collide often.
    p.wstrb = ($urandom % 2) ? 8'($urandom) : 8'h00;
    p.wdata = {$urandom, $urandom};
    p.exp_ready = p.valid;
    p.exp_rdata = '0;
  endtask

  task automatic run_random();
    step_t p0;
    step_t p1;
    int w0;
    int w1;
    repeat (random_count) begin
      random_request(p0);
      random_request(p1);
      w0 = p0.addr >> offset_bits;
      w1 = p1.addr >> offset_bits;
      if (p0.valid && p1.valid && w0 == w1 && |p0.wstrb && |p1.wstrb) begin
        p1.wstrb = '0; // two writers on one word have no defined result.
      end
      p0.exp_rdata = shadow[w0];
      p1.exp_rdata = shadow[w1];
      if (p0.valid && |p0.wstrb && p1.valid && !(|p1.wstrb) && w0 == w1) begin
        p1.exp_rdata = merge_bytes(shadow[w1], p0.wdata, p0.wstrb);
      end
      apply_step(p0, p1);
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

  initial begin
    mem0_valid = 1'b0;
    mem0_addr = '0;
    mem0_wstrb = '0;
    mem0_wdata = '0;
    mem1_valid = 1'b0;
    mem1_addr = '0;
    mem1_wstrb = '0;
    mem1_wdata = '0;
    have_pending = 1'b0;
    void'($urandom(32'h6e03));
    wait (reset === 1'b1);
    for (int i = 0; i < table_len; i++) begin
      apply_step(steps0[i], steps1[i]);
    end
    run_random();
    @(negedge clock);
    check_pending();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- tb.f
logic/tim_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/tim_bank.sv
logic/tim_port_front.sv
logic/tim_resp_merge.sv
logic/tim_top.sv
verif/tb_clock_gen.sv
verif/tim_tb.sv

//--- Bender.yml
package:
  name: tim

sources:
  - logic/tim_geom_pkg.sv
  - logic/mem_bus_pkg.sv
  - logic/tim_bank.sv
  - logic/tim_port_front.sv
  - logic/tim_resp_merge.sv
  - logic/tim_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/tim_tb.sv
